/* hdl/twi_defines.svh */
// ----------------------------------------------------------
// two-wire controller constants: register offsets,
// control bit positions and field widths
// ----------------------------------------------------------
`ifndef TWI_DEFINES_SVH
`define TWI_DEFINES_SVH

`define TWI_DATA_W        32  // host bus width
`define TWI_CTRL_ADDR     0   // control/status word offset
`define TWI_RTX_ADDR      4   // rx/tx data word offset

// control register bits
`define TWI_CTRL_EN       0   // r/w enable
`define TWI_CTRL_START    1   // -/w issue start
`define TWI_CTRL_STOP     2   // -/w issue stop
`define TWI_CTRL_MACK     3   // r/w controller ack
`define TWI_CTRL_CSEN     4   // r/w clock stretch enable
`define TWI_CTRL_PRSC_LSB 5   // prescaler select field
`define TWI_CTRL_CDIV_LSB 8   // divider field
`define TWI_CTRL_CLAIMED  29  // r/- bus claimed
`define TWI_CTRL_ACK      30  // r/- ack received
`define TWI_CTRL_BUSY     31  // r/- engine busy

`define TWI_PRSC_W        3
`define TWI_CDIV_W        4
`define TWI_TAPS_W        8   // prescaler tap vector
`define TWI_FRAME_BITS    9   // 8 data + 1 ack

`endif

/* hdl/twi_pkg.sv */
// ----------------------------------------------------------
// shared types: control fields, command pulses, status,
// phase strobes and engine state encoding
// ----------------------------------------------------------
`include "twi_defines.svh"

package twi_pkg;

    // control fields held by the register block
    typedef struct packed {
        logic                   enable;  // module on
        logic                   mack;    // controller drives ack bit
        logic                   csen;    // allow clock stretching
        logic [`TWI_PRSC_W-1:0] prsc;    // prescaler tap select
        logic [`TWI_CDIV_W-1:0] cdiv;    // tick divider
    } twi_ctrl_t;

    // one-cycle command pulses from a bus write
    typedef struct packed {
        logic       start;    // start condition request
        logic       stop;     // stop condition request
        logic       tx;       // byte transfer request
        logic [7:0] tx_byte;  // byte to shift out
    } twi_cmd_t;

    // engine status seen by the register block
    typedef struct packed {
        logic       busy;     // running or pending
        logic       claimed;  // bus in use
        logic       ack;      // ack bit of last frame
        logic [7:0] rx_byte;  // last byte shifted in
    } twi_status_t;

    // phase strobes, one cycle each
    typedef struct packed {
        logic p3;
        logic p2;
        logic p1;
        logic p0;
    } twi_phase_t;

    typedef enum logic [1:0] {
        IDLE  = 2'b00,
        START = 2'b01,
        STOP  = 2'b10,
        RTX   = 2'b11
    } twi_state_e;

endpackage

/* hdl/twi_regs.sv */
// ----------------------------------------------------------
// host bus decode, control register, command pulses
// and read-back mux
// ----------------------------------------------------------
`timescale 1ns/10ps
`include "twi_defines.svh"

module twi_regs (
    input  logic                    clk_i,
    input  logic                    rstn_i,
    input  logic [`TWI_DATA_W-1:0]  bus_addr_i,
    input  logic                    bus_rden_i,
    input  logic                    bus_wren_i,
    input  logic [`TWI_DATA_W-1:0]  bus_wdata_i,
    input  twi_pkg::twi_status_t    status_i,
    output logic [`TWI_DATA_W-1:0]  bus_rdata_o,
    output logic                    bus_ack_o,
    output twi_pkg::twi_ctrl_t      ctrl_o,
    output twi_pkg::twi_cmd_t       cmd_o,
    output logic                    clkgen_en_o
);

    logic [2:0]             word_off;  // byte offset of the word
    logic                   sel_ctrl;  // control register hit
    logic                   sel_rtx;   // data register hit
    logic [`TWI_DATA_W-1:0] rd_ctrl;   // control read-back word

    // ------------------------------------------------------
    // decode, only address bit 2 matters
    // ------------------------------------------------------
    assign word_off = {bus_addr_i[2], 2'b00};
    assign sel_ctrl = (word_off == 3'(`TWI_CTRL_ADDR));
    assign sel_rtx  = (word_off == 3'(`TWI_RTX_ADDR));

    // ------------------------------------------------------
    // control register and command pulses
    // ------------------------------------------------------
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            ctrl_o <= '0;
            cmd_o  <= '0;
        end else begin
            cmd_o.start <= bus_wren_i & sel_ctrl & bus_wdata_i[`TWI_CTRL_START];
            cmd_o.stop  <= bus_wren_i & sel_ctrl & bus_wdata_i[`TWI_CTRL_STOP];
            cmd_o.tx    <= bus_wren_i & sel_rtx;  // any data write sends a frame
            if (bus_wren_i && sel_rtx) begin
                cmd_o.tx_byte <= bus_wdata_i[7:0];
            end
            if (bus_wren_i && sel_ctrl) begin
                ctrl_o.enable <= bus_wdata_i[`TWI_CTRL_EN];
                ctrl_o.mack   <= bus_wdata_i[`TWI_CTRL_MACK];
                ctrl_o.csen   <= bus_wdata_i[`TWI_CTRL_CSEN];
                ctrl_o.prsc   <= bus_wdata_i[`TWI_CTRL_PRSC_LSB +: `TWI_PRSC_W];
                ctrl_o.cdiv   <= bus_wdata_i[`TWI_CTRL_CDIV_LSB +: `TWI_CDIV_W];
            end
        end
    end

    assign clkgen_en_o = ctrl_o.enable;  // prescaler runs only when on

    // ------------------------------------------------------
    // read-back
    // ------------------------------------------------------
    always_comb begin
        rd_ctrl                                         = '0;
        rd_ctrl[`TWI_CTRL_EN]                           = ctrl_o.enable;
        rd_ctrl[`TWI_CTRL_MACK]                         = ctrl_o.mack;
        rd_ctrl[`TWI_CTRL_CSEN]                         = ctrl_o.csen;
        rd_ctrl[`TWI_CTRL_PRSC_LSB +: `TWI_PRSC_W]      = ctrl_o.prsc;
        rd_ctrl[`TWI_CTRL_CDIV_LSB +: `TWI_CDIV_W]      = ctrl_o.cdiv;
        rd_ctrl[`TWI_CTRL_CLAIMED]                      = status_i.claimed;
        rd_ctrl[`TWI_CTRL_ACK]                          = status_i.ack;
        rd_ctrl[`TWI_CTRL_BUSY]                         = status_i.busy;
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            bus_ack_o   <= 1'b0;
            bus_rdata_o <= '0;
        end else begin
            bus_ack_o   <= bus_rden_i | bus_wren_i;  // no wait states
            bus_rdata_o <= '0;                       // zero outside a read
            if (bus_rden_i) begin
                bus_rdata_o <= sel_rtx ? `TWI_DATA_W'(status_i.rx_byte) : rd_ctrl;
            end
        end
    end

    // single-cycle request gives a single-cycle ack
    ack_one_cycle_a: assert property (@(posedge clk_i) disable iff (!rstn_i)
        ((bus_rden_i || bus_wren_i) ##1 !(bus_rden_i || bus_wren_i))
            |-> (bus_ack_o ##1 !bus_ack_o));

endmodule

/* hdl/twi_clk_gen.sv */
// ----------------------------------------------------------
// bus clock tick from prescaler taps, four-phase strobes,
// clock stretch halt
// ----------------------------------------------------------
`timescale 1ns/10ps
`include "twi_defines.svh"

module twi_clk_gen (
    input  logic                   clk_i,
    input  logic                   rstn_i,
    input  twi_pkg::twi_ctrl_t     ctrl_i,
    input  logic [`TWI_TAPS_W-1:0] clkgen_i,
    input  logic                   active_i,    // engine running a command
    input  logic                   scl_rel_i,   // engine releases scl
    input  logic                   scl_sync_i,  // synchronized scl line
    output logic                   tick_o,
    output twi_pkg::twi_phase_t    phase_o
);

    import twi_pkg::*;

    logic [`TWI_CDIV_W-1:0] cnt;        // divider count
    logic [3:0]             phase_gen;  // one-hot phase
    logic [3:0]             phase_ff;   // phase one cycle back
    logic                   halt;       // peripheral stretching scl

    // ------------------------------------------------------
    // tick divider
    // ------------------------------------------------------
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            cnt    <= '0;
            tick_o <= 1'b0;
        end else if (!ctrl_i.enable) begin
            cnt    <= '0;
            tick_o <= 1'b0;
        end else begin
            tick_o <= 1'b0;
            if (clkgen_i[ctrl_i.prsc]) begin  // selected tap high
                if (cnt == ctrl_i.cdiv) begin
                    cnt    <= '0;
                    tick_o <= 1'b1;
                end else begin
                    cnt <= cnt + 1'b1;
                end
            end
        end
    end

    // scl wanted high but still low on the wire
    assign halt = ctrl_i.csen & scl_rel_i & ~scl_sync_i;

    // ------------------------------------------------------
    // phase rotation
    // ------------------------------------------------------
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            phase_gen <= 4'b0001;
            phase_ff  <= 4'b0001;
        end else begin
            phase_ff <= phase_gen;
            if (!active_i) begin
                phase_gen <= 4'b0001;  // next command starts at phase 0
            end else if (tick_o && !halt) begin
                phase_gen <= {phase_gen[2:0], phase_gen[3]};  // rotate left
            end
        end
    end

    // strobe on the falling edge of each phase bit
    assign phase_o = twi_phase_t'(phase_ff & ~phase_gen);

    phase_onehot_a: assert property (@(posedge clk_i) disable iff (!rstn_i)
        $onehot0(phase_o));

endmodule

/* hdl/twi_engine.sv */
// ----------------------------------------------------------
// line synchronizers, start/stop/byte FSM, shift register,
// status and done interrupt
// ----------------------------------------------------------
`timescale 1ns/10ps
`include "twi_defines.svh"

module twi_engine (
    input  logic                 clk_i,
    input  logic                 rstn_i,
    input  twi_pkg::twi_ctrl_t   ctrl_i,
    input  twi_pkg::twi_cmd_t    cmd_i,
    input  logic                 tick_i,
    input  twi_pkg::twi_phase_t  phase_i,
    input  logic                 twi_sda_i,
    input  logic                 twi_scl_i,
    output twi_pkg::twi_status_t status_o,
    output logic                 active_o,
    output logic                 scl_rel_o,
    output logic                 scl_sync_o,
    output logic                 twi_sda_o,
    output logic                 twi_scl_o,
    output logic                 irq_o
);

    import twi_pkg::*;

    twi_state_e state;    // running operation
    twi_state_e pend;     // accepted, waits for a tick
    logic [1:0] sda_ff;   // sda synchronizer
    logic [1:0] scl_ff;   // scl synchronizer
    logic [8:0] sreg;     // data bits + ack bit
    logic [3:0] bitcnt;   // frame bits done
    logic       rtx_done; // frame finished
    logic       accept;   // free for a new command
    logic       busy;

    assign accept   = (state == IDLE) && (pend == IDLE);
    assign rtx_done = (bitcnt == 4'(`TWI_FRAME_BITS)) && phase_i.p0;
    assign busy     = (state != IDLE) || (pend != IDLE);

    // ------------------------------------------------------
    // FSM and line drivers
    // ------------------------------------------------------
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            sda_ff    <= 2'b11;
            scl_ff    <= 2'b11;
            state     <= IDLE;
            pend      <= IDLE;
            bitcnt    <= '0;
            twi_sda_o <= 1'b1;
            twi_scl_o <= 1'b1;
            irq_o     <= 1'b0;
        end else begin
            sda_ff <= {sda_ff[0], twi_sda_i};
            scl_ff <= {scl_ff[0], twi_scl_i};
            irq_o  <= (state == RTX) && rtx_done;
            if (!ctrl_i.enable) begin  // offline, lines released
                state     <= IDLE;
                pend      <= IDLE;
                bitcnt    <= '0;
                twi_sda_o <= 1'b1;
                twi_scl_o <= 1'b1;
            end else begin
                case (state)
                    IDLE: begin
                        bitcnt <= '0;
                        if (accept) begin
                            if (cmd_i.start)     pend <= START;
                            else if (cmd_i.stop) pend <= STOP;
                            else if (cmd_i.tx)   pend <= RTX;
                        end
                        if ((pend != IDLE) && tick_i) begin  // launch on bus clock
                            state <= pend;
                            pend  <= IDLE;
                        end
                    end
                    START: begin  // sda falls while scl high
                        if (phase_i.p0)      twi_sda_o <= 1'b1;
                        else if (phase_i.p1) twi_sda_o <= 1'b0;
                        if (phase_i.p0) begin
                            twi_scl_o <= 1'b1;
                        end else if (phase_i.p3) begin
                            twi_scl_o <= 1'b0;
                            state     <= IDLE;
                        end
                    end
                    STOP: begin  // sda rises while scl high
                        if (phase_i.p0) begin
                            twi_sda_o <= 1'b0;
                        end else if (phase_i.p3) begin
                            twi_sda_o <= 1'b1;
                            state     <= IDLE;
                        end
                        if (phase_i.p0)      twi_scl_o <= 1'b0;
                        else if (phase_i.p1) twi_scl_o <= 1'b1;
                    end
                    RTX: begin
                        if (phase_i.p0 || phase_i.p3) twi_scl_o <= 1'b0;
                        else if (phase_i.p1)          twi_scl_o <= 1'b1;
                        if (rtx_done)        twi_sda_o <= 1'b0;  // hold bus claimed
                        else if (phase_i.p0) twi_sda_o <= sreg[8];  // msb first
                        if (phase_i.p3) bitcnt <= bitcnt + 4'd1;
                        if (rtx_done)   state  <= IDLE;
                    end
                    default: state <= IDLE;
                endcase
            end
        end
    end

    // ------------------------------------------------------
    // shift register
    // ------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (!ctrl_i.enable) begin
            sreg <= '0;
        end else if (accept && cmd_i.tx && !cmd_i.start && !cmd_i.stop) begin
            sreg <= {cmd_i.tx_byte, ~ctrl_i.mack};  // ninth bit released unless mack
        end else if ((state == RTX) && phase_i.p2) begin
            sreg <= {sreg[7:0], sda_ff[1]};  // sample sda
        end
    end

    // status and clock generator hooks
    assign status_o.busy    = busy;
    assign status_o.claimed = busy | (~sda_ff[1] & ~scl_ff[1]);
    assign status_o.ack     = ~sreg[0];
    assign status_o.rx_byte = sreg[8:1];
    assign active_o         = ctrl_i.enable && (state != IDLE);
    assign scl_rel_o        = twi_scl_o;
    assign scl_sync_o       = scl_ff[1];

    irq_in_rtx_a: assert property (@(posedge clk_i) disable iff (!rstn_i)
        irq_o |-> $past(state == RTX));

endmodule

/* hdl/twi_top.sv */
// ----------------------------------------------------------
// two-wire controller top: register block, clock
// generator and engine
// ----------------------------------------------------------
`timescale 1ns/10ps
`include "twi_defines.svh"

module twi_top (
    input  logic                   clk_i,
    input  logic                   rstn_i,
    input  logic [`TWI_DATA_W-1:0] bus_addr_i,
    input  logic                   bus_rden_i,
    input  logic                   bus_wren_i,
    input  logic [`TWI_DATA_W-1:0] bus_wdata_i,
    output logic [`TWI_DATA_W-1:0] bus_rdata_o,
    output logic                   bus_ack_o,
    output logic                   clkgen_en_o,
    input  logic [`TWI_TAPS_W-1:0] clkgen_i,
    input  logic                   twi_sda_i,
    output logic                   twi_sda_o,
    input  logic                   twi_scl_i,
    output logic                   twi_scl_o,
    output logic                   irq_o
);

    import twi_pkg::*;

    twi_ctrl_t   ctrl;      // control fields
    twi_cmd_t    cmd;       // command pulses
    twi_status_t status;    // engine status
    twi_phase_t  phase;     // phase strobes
    logic        tick;      // bus clock tick
    logic        active;    // engine running
    logic        scl_rel;   // scl released by engine
    logic        scl_sync;  // scl after synchronizer

    twi_regs twi_regs_i (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .bus_addr_i  (bus_addr_i),
        .bus_rden_i  (bus_rden_i),
        .bus_wren_i  (bus_wren_i),
        .bus_wdata_i (bus_wdata_i),
        .status_i    (status),
        .bus_rdata_o (bus_rdata_o),
        .bus_ack_o   (bus_ack_o),
        .ctrl_o      (ctrl),
        .cmd_o       (cmd),
        .clkgen_en_o (clkgen_en_o)
    );

    twi_clk_gen twi_clk_gen_i (
        .clk_i      (clk_i),
        .rstn_i     (rstn_i),
        .ctrl_i     (ctrl),
        .clkgen_i   (clkgen_i),
        .active_i   (active),
        .scl_rel_i  (scl_rel),
        .scl_sync_i (scl_sync),
        .tick_o     (tick),
        .phase_o    (phase)
    );

    twi_engine twi_engine_i (
        .clk_i      (clk_i),
        .rstn_i     (rstn_i),
        .ctrl_i     (ctrl),
        .cmd_i      (cmd),
        .tick_i     (tick),
        .phase_i    (phase),
        .twi_sda_i  (twi_sda_i),
        .twi_scl_i  (twi_scl_i),
        .status_o   (status),
        .active_o   (active),
        .scl_rel_o  (scl_rel),
        .scl_sync_o (scl_sync),
        .twi_sda_o  (twi_sda_o),
        .twi_scl_o  (twi_scl_o),
        .irq_o      (irq_o)
    );

endmodule

/* dv/twi_tb.sv */
// ----------------------------------------------------------
// two-wire controller testbench: clock, reset, open-drain
// lines, peripheral model, directed tests and watchdog
// ----------------------------------------------------------
`timescale 1ns/10ps
`include "twi_defines.svh"

module twi_tb;

    localparam int          CLK_PERIOD  = 100;
    localparam int          CDIV        = 3;                                 // tick every 4 clocks
    localparam logic [2:0]  PRSC_SEL    = 3'd2;
    localparam int          BYTE_CYCLES = 4 * `TWI_FRAME_BITS * (CDIV + 1);  // 4 phases per bit
    localparam int          WATCHDOG_NS = 60 * BYTE_CYCLES * CLK_PERIOD;
    localparam int          POLL_MAX    = 2 * BYTE_CYCLES;

    logic                   clk_i;
    logic                   rstn_i;
    logic [`TWI_DATA_W-1:0] bus_addr;
    logic [`TWI_DATA_W-1:0] bus_wdata;
    logic                   bus_rden;
    logic                   bus_wren;
    logic [`TWI_DATA_W-1:0] bus_rdata_o;
    logic                   bus_ack_o;
    logic                   clkgen_en_o;
    logic [`TWI_TAPS_W-1:0] clkgen_i;
    logic                   twi_sda_o;
    logic                   twi_scl_o;
    logic                   irq_o;
    wire                    sda_line;
    wire                    scl_line;

    // peripheral model state
    logic       scl_drv     = 1'b1;   // model pulls scl
    logic       sda_drv     = 1'b1;   // model pulls sda
    logic       scl_q       = 1'b1;
    logic       sda_q       = 1'b1;
    logic       ack_en      = 1'b1;   // ack the ninth bit
    logic       rd_mode     = 1'b0;   // model sends data bits
    logic       ninth_bit   = 1'b1;
    logic [7:0] rd_byte     = 8'h00;
    logic [7:0] rx_shift    = 8'h00;  // byte seen on the wire
    int         bit_idx     = 9;      // 9 means between frames
    int         hold_cnt    = 0;
    int         stretch_len = 0;
    int         start_cnt   = 0;
    int         stop_cnt    = 0;
    int         irq_cnt     = 0;

    integer     seed        = 32'h14264b26;
    string      cur_test;
    int         errors      = 0;
    int         err_mark    = 0;
    int         tests_run   = 0;
    int         tests_fail  = 0;

    assign sda_line = twi_sda_o & sda_drv;  // wired and
    assign scl_line = twi_scl_o & scl_drv;

    twi_top twi_top_i (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .bus_addr_i  (bus_addr),
        .bus_rden_i  (bus_rden),
        .bus_wren_i  (bus_wren),
        .bus_wdata_i (bus_wdata),
        .bus_rdata_o (bus_rdata_o),
        .bus_ack_o   (bus_ack_o),
        .clkgen_en_o (clkgen_en_o),
        .clkgen_i    (clkgen_i),
        .twi_sda_i   (sda_line),
        .twi_sda_o   (twi_sda_o),
        .twi_scl_i   (scl_line),
        .twi_scl_o   (twi_scl_o),
        .irq_o       (irq_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    // ------------------------------------------------------
    // peripheral model
    // ------------------------------------------------------
    always @(posedge clk_i) begin
        scl_q <= scl_line;
        sda_q <= sda_line;
        if (scl_q && scl_line && sda_q && !sda_line) begin         // start
            start_cnt <= start_cnt + 1;
            bit_idx   <= 0;
        end else if (scl_q && scl_line && !sda_q && sda_line) begin // stop
            stop_cnt <= stop_cnt + 1;
            bit_idx  <= 9;
        end else if (!scl_q && scl_line && bit_idx < 9) begin       // scl rise, sample
            if (bit_idx < 8) rx_shift <= {rx_shift[6:0], sda_line};
            else ninth_bit <= sda_line;
            bit_idx <= bit_idx + 1;
        end else if (scl_q && !scl_line) begin                      // scl fall, next bit
            if (bit_idx == 8) sda_drv <= !ack_en;
            else if (rd_mode && bit_idx < 8) sda_drv <= rd_byte[7 - bit_idx];
            else sda_drv <= 1'b1;
            if (stretch_len != 0 && bit_idx == 4) begin  // hold scl mid-byte
                scl_drv  <= 1'b0;
                hold_cnt <= stretch_len;
            end
        end
        if (hold_cnt != 0) begin
            hold_cnt <= hold_cnt - 1;
            if (hold_cnt == 1) scl_drv <= 1'b1;
        end
    end

    always @(posedge clk_i) begin
        if (irq_o) irq_cnt <= irq_cnt + 1;
    end

    // ------------------------------------------------------
    // helpers
    // ------------------------------------------------------
    task automatic report_mismatch(input string what, input logic [31:0] exp,
                                   input logic [31:0] act);
        $display("[FAIL] %s %s expected %0h actual %0h", cur_test, what, exp, act);
        errors++;
    endtask

    task automatic begin_test(input string name);
        cur_test = name;
        err_mark = errors;
    endtask

    task automatic end_test();
        tests_run++;
        if (errors != err_mark) tests_fail++;
        $display("%s: %s", cur_test, (errors == err_mark) ? "passed" : "failed");
    endtask

    function automatic logic [31:0] ctrl_word(input logic en, input logic start,
                                              input logic stop, input logic mack,
                                              input logic csen);
        logic [31:0] w;
        w                                     = '0;
        w[`TWI_CTRL_EN]                       = en;
        w[`TWI_CTRL_START]                    = start;
        w[`TWI_CTRL_STOP]                     = stop;
        w[`TWI_CTRL_MACK]                     = mack;
        w[`TWI_CTRL_CSEN]                     = csen;
        w[`TWI_CTRL_PRSC_LSB +: `TWI_PRSC_W]  = PRSC_SEL;
        w[`TWI_CTRL_CDIV_LSB +: `TWI_CDIV_W]  = 4'(CDIV);
        return w;
    endfunction

    // single-cycle request, ack expected exactly one cycle later
    task automatic bus_access(input logic wr, input logic [31:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata);
        @(posedge clk_i);
        bus_addr  <= addr;
        bus_wdata <= wdata;
        bus_wren  <= wr;
        bus_rden  <= !wr;
        @(negedge clk_i);
        if (bus_ack_o) begin
            $display("%s: bus ack came in the request cycle", cur_test);
            errors++;
        end
        @(posedge clk_i);
        bus_wren <= 1'b0;
        bus_rden <= 1'b0;
        @(negedge clk_i);
        if (!bus_ack_o) begin
            $display("%s: no bus ack one cycle after the request", cur_test);
            errors++;
        end
        rdata = bus_rdata_o;
        @(negedge clk_i);
        if (bus_ack_o) begin
            $display("%s: bus ack stayed high for two cycles", cur_test);
            errors++;
        end
    endtask

    task automatic wait_idle(output logic [31:0] st);
        int polls;
        polls = 0;
        bus_access(1'b0, `TWI_CTRL_ADDR, 32'h0, st);
        while (st[`TWI_CTRL_BUSY] && polls < POLL_MAX) begin
            if (!st[`TWI_CTRL_CLAIMED]) report_mismatch("claimed while busy", 32'd1, 32'd0);
            bus_access(1'b0, `TWI_CTRL_ADDR, 32'h0, st);
            polls++;
        end
        if (st[`TWI_CTRL_BUSY]) begin
            $display("%s: busy did not clear after %0d polls", cur_test, polls);
            errors++;
        end
    endtask

    // ------------------------------------------------------
    // directed tests
    // ------------------------------------------------------
    task automatic reset_readback();
        logic [31:0] st;
        if (twi_scl_o !== 1'b1) report_mismatch("scl after reset", 32'd1, 32'(twi_scl_o));
        if (twi_sda_o !== 1'b1) report_mismatch("sda after reset", 32'd1, 32'(twi_sda_o));
        if (irq_o !== 1'b0) report_mismatch("irq after reset", 32'd0, 32'(irq_o));
        if (clkgen_en_o !== 1'b0) report_mismatch("clkgen_en", 32'd0, 32'(clkgen_en_o));
        // en, mack, csen set, prsc 5, cdiv 9
        bus_access(1'b1, `TWI_CTRL_ADDR, 32'h0000_09B9, st);
        bus_access(1'b0, `TWI_CTRL_ADDR, 32'h0, st);
        if ((st & 32'h0000_0FF9) !== 32'h0000_09B9) begin
            report_mismatch("ctrl fields", 32'h0000_09B9, st & 32'h0000_0FF9);
        end
        if (clkgen_en_o !== 1'b1) report_mismatch("clkgen_en", 32'd1, 32'(clkgen_en_o));
    endtask

    task automatic byte_write(input logic [7:0] tx, input logic ack, input logic csen,
                              input int stretch);
        logic [31:0] st;
        int          starts;
        int          stops;
        int          irqs;
        int          cyc;
        starts      = start_cnt;
        stops       = stop_cnt;
        irqs        = irq_cnt;
        ack_en      = ack;
        rd_mode     = 1'b0;
        stretch_len = stretch;
        bus_access(1'b1, `TWI_CTRL_ADDR, ctrl_word(1'b1, 1'b1, 1'b0, 1'b0, csen), st);
        wait_idle(st);
        if (start_cnt != starts + 1) report_mismatch("starts", 32'(starts + 1), 32'(start_cnt));
        bus_access(1'b1, `TWI_RTX_ADDR, {24'h0, tx}, st);
        if (stretch != 0) begin
            cyc = 0;
            while (hold_cnt == 0 && cyc < BYTE_CYCLES) begin
                @(negedge clk_i);
                cyc++;
            end
            stretch_len = 0;
            if (hold_cnt == 0) begin
                $display("%s: peripheral never held scl low", cur_test);
                errors++;
            end
            // look late in the hold, an unhalted frame would be over by then
            while (hold_cnt > 8) @(negedge clk_i);
            bus_access(1'b0, `TWI_CTRL_ADDR, 32'h0, st);
            if (!st[`TWI_CTRL_BUSY]) report_mismatch("busy during hold", 32'd1, 32'd0);
        end
        wait_idle(st);
        if (rx_shift !== tx) report_mismatch("byte at peripheral", 32'(tx), 32'(rx_shift));
        if (ninth_bit !== !ack) report_mismatch("ninth bit", 32'(!ack), 32'(ninth_bit));
        if (st[`TWI_CTRL_ACK] !== ack) begin
            report_mismatch("status ack", 32'(ack), 32'(st[`TWI_CTRL_ACK]));
        end
        bus_access(1'b1, `TWI_CTRL_ADDR, ctrl_word(1'b1, 1'b0, 1'b1, 1'b0, csen), st);
        wait_idle(st);
        if (stop_cnt != stops + 1) report_mismatch("stops", 32'(stops + 1), 32'(stop_cnt));
        if (irq_cnt != irqs + 1) report_mismatch("irq pulses", 32'(irqs + 1), 32'(irq_cnt));
    endtask

    task automatic byte_read();
        logic [31:0] st;
        logic [31:0] rnd;
        rnd         = $random(seed);
        rd_byte     = rnd[7:0];
        rd_mode     = 1'b1;
        ack_en      = 1'b0;  // controller owns the ninth bit
        stretch_len = 0;
        bus_access(1'b1, `TWI_CTRL_ADDR, ctrl_word(1'b1, 1'b1, 1'b0, 1'b1, 1'b0), st);
        wait_idle(st);
        bus_access(1'b1, `TWI_RTX_ADDR, 32'h0000_00FF, st);  // all ones releases sda
        wait_idle(st);
        bus_access(1'b0, `TWI_RTX_ADDR, 32'h0, st);
        if (st !== {24'h0, rd_byte}) report_mismatch("rx byte", {24'h0, rd_byte}, st);
        if (ninth_bit !== 1'b0) report_mismatch("controller ack bit", 32'd0, 32'(ninth_bit));
        bus_access(1'b1, `TWI_CTRL_ADDR, ctrl_word(1'b1, 1'b0, 1'b1, 1'b1, 1'b0), st);
        wait_idle(st);
        rd_mode = 1'b0;
    endtask

    task automatic disable_release();
        logic [31:0] st;
        bus_access(1'b1, `TWI_CTRL_ADDR, ctrl_word(1'b1, 1'b1, 1'b0, 1'b0, 1'b0), st);
        wait_idle(st);  // start leaves both lines low
        bus_access(1'b1, `TWI_RTX_ADDR, 32'h0000_0055, st);  // msb 0 keeps sda low
        bus_access(1'b0, `TWI_CTRL_ADDR, 32'h0, st);
        if (st[`TWI_CTRL_BUSY] !== 1'b1) report_mismatch("busy before disable", 32'd1, 32'd0);
        bus_access(1'b1, `TWI_CTRL_ADDR, ctrl_word(1'b0, 1'b0, 1'b0, 1'b0, 1'b0), st);
        @(negedge clk_i);
        if (twi_scl_o !== 1'b1) report_mismatch("scl released", 32'd1, 32'(twi_scl_o));
        if (twi_sda_o !== 1'b1) report_mismatch("sda released", 32'd1, 32'(twi_sda_o));
        bus_access(1'b0, `TWI_CTRL_ADDR, 32'h0, st);
        if (st[`TWI_CTRL_BUSY] !== 1'b0) report_mismatch("busy", 32'd0, 32'd1);
    endtask

    // ------------------------------------------------------
    // main sequence and watchdog
    // ------------------------------------------------------
    initial begin
        rstn_i    = 1'b0;
        bus_addr  = '0;
        bus_wdata = '0;
        bus_rden  = 1'b0;
        bus_wren  = 1'b0;
        clkgen_i  = '1;  // tap always high
        repeat (16) @(posedge clk_i);
        rstn_i <= 1'b1;
        @(negedge clk_i);
        begin_test("reset_readback");
        reset_readback();
        end_test();
        begin_test("write_ack");
        byte_write(8'hA5, 1'b1, 1'b0, 0);
        end_test();
        begin_test("write_nack");
        byte_write(8'h3C, 1'b0, 1'b0, 0);
        end_test();
        begin_test("read_mack");
        byte_read();
        end_test();
        begin_test("clock_stretch");
        byte_write(8'h96, 1'b1, 1'b1, 200);
        end_test();
        begin_test("disable");
        disable_release();
        end_test();
        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_fail, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired, tests did not finish in %0d ns", WATCHDOG_NS);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

/* tb.f */
+incdir+hdl
hdl/twi_pkg.sv
hdl/twi_regs.sv
hdl/twi_clk_gen.sv
hdl/twi_engine.sv
hdl/twi_top.sv
dv/twi_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the two-wire controller testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/10ps \
    --top-module twi_tb -f tb.f -o sim_twi
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/sim_twi)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "NO ERRORS"; then
    exit 0
fi
exit 1
